// ==== rtl/qracc_cfg.svh ====
`ifndef QRACC_CFG_SVH
`define QRACC_CFG_SVH

// Activation vector shape
`define QRACC_IN_BITS     4
`define QRACC_IN_ELEMS    8

// Weight rows, one output each
`define QRACC_OUT_ELEMS   4

// Datapath widths
`define QRACC_ACC_BITS    16
`define QRACC_OUT_BITS    8

// Activation store
`define QRACC_BUF_DEPTH   4

// Command port
`define QRACC_ADDR_BITS   2
`define QRACC_DATA_BITS   32

// Output scaling configuration
`define QRACC_SCALE_BITS  8
`define QRACC_SHIFT_BITS  4

`endif

// ==== rtl/qracc_pkg.sv ====
`include "qracc_cfg.svh"

package qracc_pkg;

    // --------------------------------------------------
    // Command encoding
    // --------------------------------------------------

    typedef enum logic [1:0] {
        CMD_WR_ACT = 2'd0,  // data word -> activation buffer[addr]
        CMD_WR_WGT = 2'd1,  // data[7:0] -> weight row addr
        CMD_WR_CFG = 2'd2,  // scale = data[7:0], shift = data[11:8]
        CMD_START  = 2'd3   // run MAC on activation buffer[addr]
    } cmd_op_e;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------

    // Element i at bits 4i+3 : 4i
    typedef logic [`QRACC_IN_ELEMS-1:0][`QRACC_IN_BITS-1:0] act_vec_t;

    // Bit i is the weight for activation element i
    typedef logic [`QRACC_IN_ELEMS-1:0] wgt_row_t;

    // One accumulator per weight row
    typedef logic [`QRACC_OUT_ELEMS-1:0][`QRACC_ACC_BITS-1:0] acc_vec_t;

    // Output j at bits 8j+7 : 8j
    typedef logic [`QRACC_OUT_ELEMS-1:0][`QRACC_OUT_BITS-1:0] out_vec_t;

endpackage

// ==== rtl/qracc_ctrl.sv ====
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qracc_ctrl (
    input  logic                          clk,
    input  logic                          rst_n_i,

    // Host command strobe
    input  logic                          cmd_valid_i,
    input  qracc_pkg::cmd_op_e            cmd_op_i,
    input  logic [`QRACC_ADDR_BITS-1:0]   cmd_addr_i,
    input  logic [`QRACC_DATA_BITS-1:0]   cmd_data_i,
    input  logic                          result_valid_i,
    output logic                          busy_o,

    // Activation buffer
    output logic                          buf_wr_en_o,
    output logic                          buf_rd_en_o,
    output logic [`QRACC_ADDR_BITS-1:0]   buf_addr_o,
    output qracc_pkg::act_vec_t           buf_wr_data_o,

    // Weights and MAC start
    output logic                          wgt_wr_en_o,
    output logic [`QRACC_ADDR_BITS-1:0]   wgt_row_o,
    output qracc_pkg::wgt_row_t           wgt_data_o,
    output logic                          start_mac_o,

    // Scaler configuration
    output logic [`QRACC_SCALE_BITS-1:0]  scale_o,
    output logic [`QRACC_SHIFT_BITS-1:0]  shift_o
);

    import qracc_pkg::*;

    logic                          accept;
    logic                          cfg_wr;
    logic                          start_req;
    logic                          busy_q;
    logic                          rd_req_q;
    logic                          start_q;
    logic [`QRACC_ADDR_BITS-1:0]   rd_addr_q;
    logic [`QRACC_SCALE_BITS-1:0]  scale_q;
    logic [`QRACC_SHIFT_BITS-1:0]  shift_q;

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------

    // Commands arriving while busy are dropped
    assign accept = cmd_valid_i && !busy_q;

    always_comb begin
        buf_wr_en_o = 1'b0;
        wgt_wr_en_o = 1'b0;
        cfg_wr      = 1'b0;
        start_req   = 1'b0;
        if (accept) begin
            case (cmd_op_i)
                CMD_WR_ACT: buf_wr_en_o = 1'b1;
                CMD_WR_WGT: wgt_wr_en_o = 1'b1;
                CMD_WR_CFG: cfg_wr      = 1'b1;
                default:    start_req   = 1'b1;
            endcase
        end
    end

    // Writes take effect on the accepting edge
    assign buf_wr_data_o = cmd_data_i;
    assign wgt_row_o     = cmd_addr_i;
    assign wgt_data_o    = cmd_data_i[`QRACC_IN_ELEMS-1:0];

    // Read address is held from the start command
    assign buf_addr_o  = rd_req_q ? rd_addr_q : cmd_addr_i;
    assign buf_rd_en_o = rd_req_q;
    assign start_mac_o = start_q;

    // --------------------------------------------------
    // Start sequencing
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            rd_req_q  <= 1'b0;
            start_q   <= 1'b0;
            rd_addr_q <= '0;
        end else begin
            rd_req_q <= start_req;
            // start_mac lines up with valid buffer read data
            start_q  <= rd_req_q;
            if (start_req) begin
                busy_q    <= 1'b1;
                rd_addr_q <= cmd_addr_i;
            end else if (result_valid_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign busy_o = busy_q;

    // Scale and shift registers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scale_q <= `QRACC_SCALE_BITS'(1);
            shift_q <= '0;
        end else if (cfg_wr) begin
            scale_q <= cmd_data_i[`QRACC_SCALE_BITS-1:0];
            shift_q <= cmd_data_i[`QRACC_SCALE_BITS +: `QRACC_SHIFT_BITS];
        end
    end

    assign scale_o = scale_q;
    assign shift_o = shift_q;

endmodule

// ==== rtl/activation_buffer.sv ====
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module activation_buffer #(
    parameter int DEPTH = `QRACC_BUF_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  logic                         wr_en_i,
    input  logic                         rd_en_i,
    input  logic [`QRACC_ADDR_BITS-1:0]  addr_i,
    input  qracc_pkg::act_vec_t          wr_data_i,
    output qracc_pkg::act_vec_t          rd_data_o
);

    import qracc_pkg::*;

    // Index bits actually used for the given depth
    localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    act_vec_t              mem [DEPTH];
    act_vec_t              rd_data_q;
    logic [IDX_BITS-1:0]   idx;

    assign idx = addr_i[IDX_BITS-1:0];

    // --------------------------------------------------
    // Storage and registered read
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < DEPTH; k++) begin
                mem[k] <= '0;
            end
            rd_data_q <= '0;
        end else begin
            if (wr_en_i) begin
                mem[idx] <= wr_data_i;
            end
            // Holds the last vector when no read is requested
            if (rd_en_i) begin
                rd_data_q <= mem[idx];
            end
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

// ==== rtl/seq_acc.sv ====
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module seq_acc (
    input  logic                         clk,
    input  logic                         rst_n_i,

    // Weight row writes
    input  logic                         wgt_wr_en_i,
    input  logic [`QRACC_ADDR_BITS-1:0]  wgt_row_i,
    input  qracc_pkg::wgt_row_t          wgt_data_i,

    // Activation vector in, accumulators out
    input  logic                         mac_valid_i,
    input  qracc_pkg::act_vec_t          mac_data_i,
    output logic                         valid_o,
    output qracc_pkg::acc_vec_t          mac_data_o
);

    import qracc_pkg::*;

    localparam int PLANE_BITS = $clog2(`QRACC_IN_BITS);
    localparam int CNT_BITS   = $clog2(`QRACC_IN_ELEMS + 1);

    wgt_row_t                weights [`QRACC_OUT_ELEMS];
    act_vec_t                act_q;
    acc_vec_t                acc_q;
    logic [PLANE_BITS-1:0]   plane_q;
    logic                    running_q;
    logic                    valid_q;

    act_vec_t                cur_vec;
    logic [PLANE_BITS-1:0]   cur_plane;
    acc_vec_t                acc_base;
    acc_vec_t                acc_next;

    // --------------------------------------------------
    // Weight rows
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `QRACC_OUT_ELEMS; r++) begin
                weights[r] <= '0;
            end
        end else if (wgt_wr_en_i) begin
            weights[wgt_row_i] <= wgt_data_i;
        end
    end

    // --------------------------------------------------
    // Bit-serial shift-accumulate
    // --------------------------------------------------

    // On the load edge the MSB plane comes straight from the input
    // with a cleared accumulator
    assign cur_vec   = mac_valid_i ? mac_data_i : act_q;
    assign cur_plane = mac_valid_i ? PLANE_BITS'(`QRACC_IN_BITS - 1) : plane_q;
    assign acc_base  = mac_valid_i ? '0 : acc_q;

    always_comb begin
        logic [CNT_BITS-1:0] cnt;
        for (int j = 0; j < `QRACC_OUT_ELEMS; j++) begin
            cnt = '0;
            for (int i = 0; i < `QRACC_IN_ELEMS; i++) begin
                cnt = cnt + CNT_BITS'(cur_vec[i][cur_plane] & weights[j][i]);
            end
            acc_next[j] = {acc_base[j][`QRACC_ACC_BITS-2:0], 1'b0}
                        + `QRACC_ACC_BITS'(cnt);
        end
    end

    // Plane counter and done pulse
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            running_q <= 1'b0;
            plane_q   <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (mac_valid_i) begin
                running_q <= 1'b1;
                plane_q   <= PLANE_BITS'(`QRACC_IN_BITS - 2);
            end else if (running_q) begin
                if (plane_q == '0) begin
                    running_q <= 1'b0;
                    valid_q   <= 1'b1;
                end else begin
                    plane_q <= plane_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mac_valid_i) begin
            act_q <= mac_data_i;
        end
        if (mac_valid_i || running_q) begin
            acc_q <= acc_next;
        end
    end

    assign valid_o    = valid_q;
    assign mac_data_o = acc_q;

endmodule

// ==== rtl/output_scaler.sv ====
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module output_scaler (
    input  logic                          clk,
    input  logic                          rst_n_i,

    input  logic                          wx_valid_i,
    input  qracc_pkg::acc_vec_t           wx_i,
    input  logic [`QRACC_SCALE_BITS-1:0]  output_scale_i,
    input  logic [`QRACC_SHIFT_BITS-1:0]  output_shift_i,

    output logic                          y_valid_o,
    output qracc_pkg::out_vec_t           y_o
);

    import qracc_pkg::*;

    localparam int PROD_BITS = `QRACC_ACC_BITS + `QRACC_SCALE_BITS;

    out_vec_t  y_next;
    out_vec_t  y_q;
    logic      y_valid_q;

    // --------------------------------------------------
    // Scale, shift and saturate
    // --------------------------------------------------

    always_comb begin
        logic [PROD_BITS-1:0] prod;
        logic [PROD_BITS-1:0] shifted;
        for (int j = 0; j < `QRACC_OUT_ELEMS; j++) begin
            prod    = PROD_BITS'(wx_i[j]) * PROD_BITS'(output_scale_i);
            shifted = prod >> output_shift_i;
            // Clamp anything above the 8-bit range
            if (|shifted[PROD_BITS-1:`QRACC_OUT_BITS]) begin
                y_next[j] = '1;
            end else begin
                y_next[j] = shifted[`QRACC_OUT_BITS-1:0];
            end
        end
    end

    // Result word is held until the next valid
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            y_valid_q <= 1'b0;
            y_q       <= '0;
        end else begin
            y_valid_q <= wx_valid_i;
            if (wx_valid_i) begin
                y_q <= y_next;
            end
        end
    end

    assign y_valid_o = y_valid_q;
    assign y_o       = y_q;

endmodule

// ==== rtl/qr_acc_top.sv ====
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qr_acc_top (
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  logic                         cmd_valid_i,
    input  qracc_pkg::cmd_op_e           cmd_op_i,
    input  logic [`QRACC_ADDR_BITS-1:0]  cmd_addr_i,
    input  logic [`QRACC_DATA_BITS-1:0]  cmd_data_i,

    output logic                         busy_o,
    output logic                         result_valid_o,
    output qracc_pkg::out_vec_t          result_data_o
);

    import qracc_pkg::*;

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------

    logic                          buf_wr_en;
    logic                          buf_rd_en;
    logic [`QRACC_ADDR_BITS-1:0]   buf_addr;
    act_vec_t                      buf_wr_data;
    act_vec_t                      buf_rd_data;

    logic                          wgt_wr_en;
    logic [`QRACC_ADDR_BITS-1:0]   wgt_row;
    wgt_row_t                      wgt_data;
    logic                          start_mac;

    logic                          acc_valid;
    acc_vec_t                      acc_data;
    logic [`QRACC_SCALE_BITS-1:0]  scale;
    logic [`QRACC_SHIFT_BITS-1:0]  shift;

    // Decode
    qracc_ctrl u_qracc_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_op_i       (cmd_op_i),
        .cmd_addr_i     (cmd_addr_i),
        .cmd_data_i     (cmd_data_i),
        .result_valid_i (result_valid_o),
        .busy_o         (busy_o),
        .buf_wr_en_o    (buf_wr_en),
        .buf_rd_en_o    (buf_rd_en),
        .buf_addr_o     (buf_addr),
        .buf_wr_data_o  (buf_wr_data),
        .wgt_wr_en_o    (wgt_wr_en),
        .wgt_row_o      (wgt_row),
        .wgt_data_o     (wgt_data),
        .start_mac_o    (start_mac),
        .scale_o        (scale),
        .shift_o        (shift)
    );

    activation_buffer #(
        .DEPTH          (`QRACC_BUF_DEPTH)
    ) u_activation_buffer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wr_en_i        (buf_wr_en),
        .rd_en_i        (buf_rd_en),
        .addr_i         (buf_addr),
        .wr_data_i      (buf_wr_data),
        .rd_data_o      (buf_rd_data)
    );

    // Execute
    seq_acc u_seq_acc (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wgt_wr_en_i    (wgt_wr_en),
        .wgt_row_i      (wgt_row),
        .wgt_data_i     (wgt_data),
        .mac_valid_i    (start_mac),
        .mac_data_i     (buf_rd_data),
        .valid_o        (acc_valid),
        .mac_data_o     (acc_data)
    );

    // Result
    output_scaler u_output_scaler (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wx_valid_i     (acc_valid),
        .wx_i           (acc_data),
        .output_scale_i (scale),
        .output_shift_i (shift),
        .y_valid_o      (result_valid_o),
        .y_o            (result_data_o)
    );

endmodule

// ==== sim/tb_qr_acc_top.sv ====
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module tb_qr_acc_top;

    import qracc_pkg::*;

    logic                          clk = 1'b0;
    logic                          rst_n_i;
    logic                          cmd_valid_i;
    cmd_op_e                       cmd_op_i;
    logic [`QRACC_ADDR_BITS-1:0]   cmd_addr_i;
    logic [`QRACC_DATA_BITS-1:0]   cmd_data_i;
    logic                          busy_o;
    logic                          result_valid_o;
    out_vec_t                      result_data_o;

    int                            errors = 0;

    // Host-side view of what the DUT should hold
    logic [`QRACC_IN_ELEMS-1:0]    wgt_model [`QRACC_OUT_ELEMS];
    logic [31:0]                   act_model [`QRACC_BUF_DEPTH];
    logic [`QRACC_SCALE_BITS-1:0]  scale_model;
    logic [`QRACC_SHIFT_BITS-1:0]  shift_model;

    qr_acc_top u_qr_acc_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_op_i       (cmd_op_i),
        .cmd_addr_i     (cmd_addr_i),
        .cmd_data_i     (cmd_data_i),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Returns at the edge that samples the command
    task automatic send_cmd(input cmd_op_e op, input logic [`QRACC_ADDR_BITS-1:0] addr,
                            input logic [31:0] data);
        @(posedge clk);
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= op;
        cmd_addr_i  <= addr;
        cmd_data_i  <= data;
        @(posedge clk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic write_weight(input int row, input logic [7:0] data);
        send_cmd(CMD_WR_WGT, `QRACC_ADDR_BITS'(row), {24'h0, data});
        wgt_model[row] = data;
    endtask

    task automatic write_act(input int addr, input logic [31:0] vec);
        send_cmd(CMD_WR_ACT, `QRACC_ADDR_BITS'(addr), vec);
        act_model[addr] = vec;
    endtask

    task automatic write_config(input logic [7:0] scale, input logic [3:0] shift);
        send_cmd(CMD_WR_CFG, '0, {20'h0, shift, scale});
        scale_model = scale;
        shift_model = shift;
    endtask

    // Counts edges from the start edge, samples at the falling edge
    task automatic wait_result(output int edges, output bit found);
        edges = 0;
        found = 1'b0;
        while (!found && edges < 50) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (result_valid_o) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Timeout: result_valid_o did not rise within 50 cycles at %0t", $time);
            errors++;
        end
    endtask

    // Sum of enabled activations, scaled, shifted, clamped to 8 bits
    function automatic logic [31:0] expected_word(input logic [31:0] act);
        logic [31:0] word;
        int          sum;
        int          val;
        word = '0;
        for (int j = 0; j < `QRACC_OUT_ELEMS; j++) begin
            sum = 0;
            for (int i = 0; i < `QRACC_IN_ELEMS; i++) begin
                if (wgt_model[j][i]) begin
                    sum = sum + int'(act[4*i +: 4]);
                end
            end
            val = (sum * int'(scale_model)) >> shift_model;
            if (val > 255) begin
                val = 255;
            end
            word[8*j +: 8] = 8'(val);
        end
        return word;
    endfunction

    task automatic start_and_check(input int addr, output int edges);
        bit found;
        send_cmd(CMD_START, `QRACC_ADDR_BITS'(addr), '0);
        wait_result(edges, found);
        if (found) begin
            check_val("result_data_o", result_data_o, expected_word(act_model[addr]));
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset();
        check_val("busy_o", 32'(busy_o), 0);
        check_val("result_valid_o", 32'(result_valid_o), 0);
        check_val("result_data_o", result_data_o, 0);
    endtask

    task automatic test_basic();
        int edges;
        write_weight(0, 8'hFF);
        write_weight(1, 8'h0F);
        write_weight(2, 8'hA5);
        write_weight(3, 8'h81);
        write_act(1, 32'h7A3F_1C52);
        start_and_check(1, edges);
        check_val("result_edges", edges, 6);
        check_val("busy_o", 32'(busy_o), 1);
        @(negedge clk);
        check_val("busy_o", 32'(busy_o), 0);
        check_val("result_valid_o", 32'(result_valid_o), 0);
    endtask

    task automatic test_buffer();
        int edges;
        for (int a = 0; a < `QRACC_BUF_DEPTH; a++) begin
            write_act(a, $urandom());
        end
        for (int a = 0; a < `QRACC_BUF_DEPTH; a++) begin
            start_and_check(a, edges);
        end
    endtask

    task automatic test_scaling();
        int edges;
        write_config(8'($urandom_range(255, 2)), 4'($urandom_range(6, 1)));
        start_and_check(2, edges);
        write_config(8'd255, 4'd0);
        for (int r = 0; r < `QRACC_OUT_ELEMS; r++) begin
            write_weight(r, 8'hFF);
        end
        write_act(3, 32'hFFFF_FFFF);
        start_and_check(3, edges);
        check_val("saturated result", result_data_o, 32'hFFFF_FFFF);
    endtask

    task automatic test_busy_drop();
        int          pulses;
        logic [31:0] exp;
        write_config(8'd1, 4'd0);
        write_weight(0, 8'h3C);
        write_weight(1, 8'hC3);
        write_act(0, 32'h1234_5678);
        write_act(1, 32'hFEDC_BA98);
        exp = expected_word(act_model[0]);
        send_cmd(CMD_START, 2'd0, '0);
        // Second start lands on the buffer read edge with another address
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= CMD_START;
        cmd_addr_i  <= 2'd1;
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        // Weight write while the MAC is still running
        send_cmd(CMD_WR_WGT, 2'd0, 32'h0000_00FF);
        pulses = 0;
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            if (result_valid_o) begin
                pulses++;
                check_val("result_data_o", result_data_o, exp);
            end
        end
        check_val("result pulses", pulses, 1);
    endtask

    task automatic test_random();
        int edges;
        int addr;
        for (int n = 0; n < 20; n++) begin
            for (int r = 0; r < `QRACC_OUT_ELEMS; r++) begin
                write_weight(r, 8'($urandom()));
            end
            addr = int'($urandom_range(`QRACC_BUF_DEPTH - 1, 0));
            write_act(addr, $urandom());
            write_config(8'($urandom()), 4'($urandom()));
            start_and_check(addr, edges);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        void'($urandom(32'h7629_04d6));
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = CMD_WR_ACT;
        cmd_addr_i  = '0;
        cmd_data_i  = '0;
        for (int r = 0; r < `QRACC_OUT_ELEMS; r++) begin
            wgt_model[r] = '0;
        end
        for (int a = 0; a < `QRACC_BUF_DEPTH; a++) begin
            act_model[a] = '0;
        end
        scale_model = 8'd1;
        shift_model = 4'd0;

        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);

        test_reset();
        test_basic();
        test_buffer();
        test_scaling();
        test_busy_drop();
        test_random();

        $display("Checks done, error count: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/qracc_pkg.sv
rtl/qracc_ctrl.sv
rtl/activation_buffer.sv
rtl/seq_acc.sv
rtl/output_scaler.sv
rtl/qr_acc_top.sv
sim/tb_qr_acc_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_qr_acc_top -f compile.f

out=$(./obj_dir/Vtb_qr_acc_top)
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
    exit 0
else
    exit 1
fi
